// ==== rtl/odd_pipe_cfg.svh ====
`ifndef ODD_PIPE_CFG_SVH
`define ODD_PIPE_CFG_SVH

// Datapath widths
`define ODD_QW_BITS    128  // One quadword
`define ODD_ADDR_BITS  7    // Register address, 128 registers
`define ODD_PC_BITS    8    // Program counter
`define ODD_IMM_BITS   10   // Immediate field

`define ODD_LS_WORDS   64   // Local store depth in quadwords

// Forwarding chain and unit latencies in cycles
`define ODD_FW_SLOTS   7    // Slot 0 is always empty
`define ODD_LAT_BR     1
`define ODD_LAT_PERM   4
`define ODD_LAT_LS     6
`define ODD_WB_LAT     7    // Issue to writeback for every unit

`endif

// ==== rtl/odd_pipe_pkg.sv ====
package odd_pipe_pkg;

	// Target execution unit of an issued instruction
	typedef enum logic [1:0] {
		unit_perm = 2'd0,
		unit_ls   = 2'd1,
		unit_br   = 2'd2,
		unit_none = 2'd3   // Falls back to the permute unit
	} unit_e;

	// Odd pipe opcodes, format already folded in by decode
	typedef enum logic [3:0] {
		op_nop     = 4'd0,
		op_shlqbyi = 4'd1,  // Shift left by imm bytes, zero fill
		op_rotqbyi = 4'd2,  // Rotate left by imm bytes
		op_lqd     = 4'd3,  // Load quadword at ra word0 + imm
		op_stqd    = 4'd4,  // Store rt_st at ra word0 + imm
		op_br      = 4'd5,  // Unconditional, pc + imm
		op_brz     = 4'd6,  // Taken if rb word0 is zero
		op_brsl    = 4'd7   // Branch and link, rt gets pc + 1
	} odd_op_e;

endpackage

// ==== rtl/odd_issue_if.sv ====
`include "odd_pipe_cfg.svh"

interface odd_issue_if;

	logic                          issue;      // One cycle strobe per instruction
	odd_pipe_pkg::odd_op_e         op;
	logic [`ODD_ADDR_BITS-1:0]     rt_addr;    // Destination register
	logic [`ODD_QW_BITS-1:0]       ra;
	logic [`ODD_QW_BITS-1:0]       rb;
	logic [`ODD_QW_BITS-1:0]       rt_st;      // Store data
	logic [`ODD_IMM_BITS-1:0]      imm;
	logic                          reg_write;  // Instruction writes a register
	logic [`ODD_PC_BITS-1:0]       pc;

	// Issue side, inside the top level
	modport dispatch (
		output issue, op, rt_addr, ra, rb, rt_st, imm, reg_write, pc
	);

	// Execution unit side
	modport unit (
		input issue, op, rt_addr, ra, rb, rt_st, imm, reg_write, pc
	);

endinterface

// ==== rtl/permute_unit.sv ====
`include "odd_pipe_cfg.svh"

module permute_unit (
	input  logic                      clk,
	input  logic                      reset,
	odd_issue_if.unit                 iss,
	output logic [`ODD_QW_BITS-1:0]   data,
	output logic [`ODD_ADDR_BITS-1:0] addr,
	output logic                      write
);

	localparam int STAGES = `ODD_LAT_PERM;

	logic [3:0]                nbytes;                 // Byte count from imm
	logic [6:0]                nbits;
	logic [`ODD_QW_BITS-1:0]   shl_q;
	logic [`ODD_QW_BITS-1:0]   rot_q;
	logic [`ODD_QW_BITS-1:0]   result;
	logic [`ODD_QW_BITS-1:0]   data_q [1:STAGES];      // Result pipeline
	logic [`ODD_ADDR_BITS-1:0] addr_q [1:STAGES];
	logic [STAGES:1]           write_q;                // Valid and write, per stage

	always_comb begin
		nbytes = iss.imm[3:0];                         // Only 16 byte positions
		nbits = {nbytes, 3'b000};
		shl_q = iss.ra << nbits;                       // Zeros shift in from the right
		// Wrapped bytes come back on the right; a zero count shifts everything out
		rot_q = shl_q | (iss.ra >> (`ODD_QW_BITS - int'(nbits)));
		case (iss.op)
			odd_pipe_pkg::op_shlqbyi: result = shl_q;
			odd_pipe_pkg::op_rotqbyi: result = rot_q;
			default: result = iss.ra;                  // Not a permute op, pass ra
		endcase
	end

	// Valid bits
	always_ff @(posedge clk) begin
		if (reset) begin
			write_q <= '0;
		end else begin
			write_q[1] <= iss.issue && iss.reg_write;  // Stage 1
			for (int s = 2; s <= STAGES; s++) begin
				write_q[s] <= write_q[s-1];
			end
		end
	end

	// Payload
	always_ff @(posedge clk) begin
		data_q[1] <= result;
		addr_q[1] <= iss.rt_addr;
		for (int s = 2; s <= STAGES; s++) begin
			data_q[s] <= data_q[s-1];
			addr_q[s] <= addr_q[s-1];
		end
	end

	assign data = data_q[STAGES];                      // Presented after the last stage
	assign addr = addr_q[STAGES];
	assign write = write_q[STAGES];

endmodule

// ==== rtl/local_store_unit.sv ====
`include "odd_pipe_cfg.svh"

module local_store_unit (
	input  logic                      clk,
	input  logic                      reset,
	odd_issue_if.unit                 iss,
	output logic [`ODD_QW_BITS-1:0]   data,
	output logic [`ODD_ADDR_BITS-1:0] addr,
	output logic                      write
);

	localparam int STAGES = `ODD_LAT_LS;
	localparam int LS_AW = $clog2(`ODD_LS_WORDS);

	logic [`ODD_QW_BITS-1:0]   mem [0:`ODD_LS_WORDS-1]; // Local store array
	logic [LS_AW-1:0]          ls_addr;
	logic                      is_load;
	logic                      is_store;
	logic [`ODD_QW_BITS-1:0]   data_q [1:STAGES];
	logic [`ODD_ADDR_BITS-1:0] addr_q [1:STAGES];
	logic [STAGES:1]           write_q;

	always_comb begin
		// Word 0 is the most significant word of ra; the sum wraps at the depth
		ls_addr = iss.ra[`ODD_QW_BITS-32 +: LS_AW] + iss.imm[LS_AW-1:0];
		is_load = iss.issue && (iss.op == odd_pipe_pkg::op_lqd);
		is_store = iss.issue && (iss.op == odd_pipe_pkg::op_stqd);
	end

	// Memory write in stage 1
	always_ff @(posedge clk) begin
		if (is_store) begin
			mem[ls_addr] <= iss.rt_st;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			write_q <= '0;
		end else begin
			write_q[1] <= is_load && iss.reg_write;   // Stores never write back
			for (int s = 2; s <= STAGES; s++) begin
				write_q[s] <= write_q[s-1];
			end
		end
	end

	// Read in stage 1 sees any store from an earlier cycle
	always_ff @(posedge clk) begin
		data_q[1] <= mem[ls_addr];
		addr_q[1] <= iss.rt_addr;
		for (int s = 2; s <= STAGES; s++) begin
			data_q[s] <= data_q[s-1];
			addr_q[s] <= addr_q[s-1];
		end
	end

	assign data = data_q[STAGES];
	assign addr = addr_q[STAGES];
	assign write = write_q[STAGES];

endmodule

// ==== rtl/branch_unit.sv ====
`include "odd_pipe_cfg.svh"

module branch_unit (
	input  logic                      clk,
	input  logic                      reset,
	odd_issue_if.unit                 iss,
	input  logic                      first,         // Branch is first of its pair
	output logic [`ODD_QW_BITS-1:0]   data,          // Link value
	output logic [`ODD_ADDR_BITS-1:0] addr,
	output logic                      write,
	output logic [`ODD_PC_BITS-1:0]   pc_wb,         // Branch target
	output logic                      branch_taken,
	output logic                      branch_kill    // Drop the twin instruction
);

	logic taken;
	logic link;

	always_comb begin
		case (iss.op)
			odd_pipe_pkg::op_br,
			odd_pipe_pkg::op_brsl: taken = 1'b1;
			odd_pipe_pkg::op_brz: taken = (iss.rb[`ODD_QW_BITS-1 -: 32] == 32'd0);  // rb word0
			default: taken = 1'b0;
		endcase
		link = (iss.op == odd_pipe_pkg::op_brsl) && iss.reg_write;
	end

	// Decision, single stage
	always_ff @(posedge clk) begin
		if (reset) begin
			branch_taken <= 1'b0;
			branch_kill <= 1'b0;
			write <= 1'b0;
		end else begin
			branch_taken <= iss.issue && taken;
			branch_kill <= iss.issue && taken && first;
			write <= iss.issue && link;
		end
	end

	// Target and link value, held until the next branch
	always_ff @(posedge clk) begin
		if (iss.issue) begin
			pc_wb <= iss.pc + iss.imm[`ODD_PC_BITS-1:0];  // Relative target, wraps
			data <= {{(`ODD_QW_BITS-`ODD_PC_BITS){1'b0}}, iss.pc + `ODD_PC_BITS'(1)};
			addr <= iss.rt_addr;
		end
	end

endmodule

// ==== rtl/odd_pipe.sv ====
`include "odd_pipe_cfg.svh"

module odd_pipe (
	input  logic                                         clk,
	input  logic                                         reset,
	input  logic                                         issue,
	input  odd_pipe_pkg::unit_e                          unit,
	input  odd_pipe_pkg::odd_op_e                        op,
	input  logic [`ODD_ADDR_BITS-1:0]                    rt_addr,
	input  logic [`ODD_QW_BITS-1:0]                      ra,
	input  logic [`ODD_QW_BITS-1:0]                      rb,
	input  logic [`ODD_QW_BITS-1:0]                      rt_st,
	input  logic [`ODD_IMM_BITS-1:0]                     imm,
	input  logic                                         reg_write,
	input  logic [`ODD_PC_BITS-1:0]                      pc_in,
	input  logic                                         first,
	output logic [`ODD_QW_BITS-1:0]                      rt_wb,
	output logic [`ODD_ADDR_BITS-1:0]                    rt_addr_wb,
	output logic                                         reg_write_wb,
	output logic [`ODD_PC_BITS-1:0]                      pc_wb,
	output logic                                         branch_taken,
	output logic                                         branch_kill,
	output logic [`ODD_FW_SLOTS-1:0][`ODD_QW_BITS-1:0]   fw_data,  // Every slot, for forwarding
	output logic [`ODD_FW_SLOTS-1:0][`ODD_ADDR_BITS-1:0] fw_addr,
	output logic [`ODD_FW_SLOTS-1:0]                     fw_write
);

	localparam int SLOTS = `ODD_FW_SLOTS;

	logic [2:0]                unit_iss;                        // 0 perm, 1 ls, 2 br
	logic [`ODD_QW_BITS-1:0]   perm_data, ls_data, br_data;
	logic [`ODD_ADDR_BITS-1:0] perm_addr, ls_addr, br_addr;
	logic                      perm_write, ls_write, br_write;
	logic [`ODD_QW_BITS-1:0]   slot_data [1:SLOTS-1];           // Chain registers
	logic [`ODD_ADDR_BITS-1:0] slot_addr [1:SLOTS-1];
	logic [SLOTS-1:1]          slot_write;

	odd_issue_if iss_if [3] ();

	// Unit select; a taken branch swallows the instruction now at issue
	always_comb begin
		unit_iss = 3'b000;
		case (unit)
			odd_pipe_pkg::unit_ls: unit_iss[1] = issue && !branch_taken;
			odd_pipe_pkg::unit_br: unit_iss[2] = issue && !branch_taken;
			default: unit_iss[0] = issue && !branch_taken;  // unit_none goes to permute
		endcase
	end

	// Operands go to all units, only the strobe is steered
	for (genvar g = 0; g < 3; g++) begin : g_dispatch
		assign iss_if[g].issue = unit_iss[g];
		assign iss_if[g].op = op;
		assign iss_if[g].rt_addr = rt_addr;
		assign iss_if[g].ra = ra;
		assign iss_if[g].rb = rb;
		assign iss_if[g].rt_st = rt_st;
		assign iss_if[g].imm = imm;
		assign iss_if[g].reg_write = reg_write;
		assign iss_if[g].pc = pc_in;
	end

	permute_unit u_perm (
		.clk(clk), .reset(reset), .iss(iss_if[0]),
		.data(perm_data), .addr(perm_addr), .write(perm_write)
	);

	local_store_unit u_ls (
		.clk(clk), .reset(reset), .iss(iss_if[1]),
		.data(ls_data), .addr(ls_addr), .write(ls_write)
	);

	branch_unit u_br (
		.clk(clk), .reset(reset), .iss(iss_if[2]), .first(first),
		.data(br_data), .addr(br_addr), .write(br_write),
		.pc_wb(pc_wb), .branch_taken(branch_taken), .branch_kill(branch_kill)
	);

	// Forwarding chain; each unit drops its result into the slot of its latency
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int n = 1; n < SLOTS; n++) begin
				slot_data[n] <= '0;
				slot_addr[n] <= '0;
				slot_write[n] <= 1'b0;
			end
			rt_wb <= '0;
			rt_addr_wb <= '0;
			reg_write_wb <= 1'b0;
		end else begin
			slot_data[1] <= '0;                                 // Shift in empty slot 0
			slot_addr[1] <= '0;
			slot_write[1] <= 1'b0;
			for (int n = 2; n < SLOTS; n++) begin
				slot_data[n] <= slot_data[n-1];
				slot_addr[n] <= slot_addr[n-1];
				slot_write[n] <= slot_write[n-1];
			end
			if (br_write) begin                                 // Link value
				slot_data[`ODD_LAT_BR] <= br_data;
				slot_addr[`ODD_LAT_BR] <= br_addr;
				slot_write[`ODD_LAT_BR] <= 1'b1;
			end
			if (perm_write) begin
				slot_data[`ODD_LAT_PERM] <= perm_data;
				slot_addr[`ODD_LAT_PERM] <= perm_addr;
				slot_write[`ODD_LAT_PERM] <= 1'b1;
			end
			if (ls_write) begin                                 // Load data
				slot_data[`ODD_LAT_LS] <= ls_data;
				slot_addr[`ODD_LAT_LS] <= ls_addr;
				slot_write[`ODD_LAT_LS] <= 1'b1;
			end
			rt_wb <= slot_data[`ODD_WB_LAT-1];                  // Writeback register
			rt_addr_wb <= slot_addr[`ODD_WB_LAT-1];
			reg_write_wb <= slot_write[`ODD_WB_LAT-1];
		end
	end

	// Slot 0 never holds a result
	always_comb begin
		fw_data[0] = '0;
		fw_addr[0] = '0;
		fw_write[0] = 1'b0;
		for (int n = 1; n < SLOTS; n++) begin
			fw_data[n] = slot_data[n];
			fw_addr[n] = slot_addr[n];
			fw_write[n] = slot_write[n];
		end
	end

endmodule

// ==== bench/odd_pipe_vectors.svh ====
// Columns: name, unit, opcode, rt address, imm, pc, reg_write, first, rb word0 zero
// One row per cycle; expected values are filled in by add_row
task automatic load_table();
	add_row("shl_3", odd_pipe_pkg::unit_perm, odd_pipe_pkg::op_shlqbyi, 10, 3, 0, 1, 0, 0);
	add_row("rot_5", odd_pipe_pkg::unit_perm, odd_pipe_pkg::op_rotqbyi, 11, 5, 0, 1, 0, 0);
	add_row("rot_0", odd_pipe_pkg::unit_perm, odd_pipe_pkg::op_rotqbyi, 12, 0, 0, 1, 0, 0);
	add_row("shl_imm18", odd_pipe_pkg::unit_none, odd_pipe_pkg::op_shlqbyi, 13, 18, 0, 1, 0, 0);
	add_row("st_a", odd_pipe_pkg::unit_ls, odd_pipe_pkg::op_stqd, 0, 4, 0, 0, 0, 0);
	add_row("st_b", odd_pipe_pkg::unit_ls, odd_pipe_pkg::op_stqd, 0, 9, 0, 0, 0, 0);
	add_row("ld_a", odd_pipe_pkg::unit_ls, odd_pipe_pkg::op_lqd, 20, 4, 0, 1, 0, 0);
	add_row("no_write", odd_pipe_pkg::unit_perm, odd_pipe_pkg::op_rotqbyi, 14, 1, 0, 0, 0, 0);
	add_row("brz_zero", odd_pipe_pkg::unit_br, odd_pipe_pkg::op_brz, 0, 8, 40, 0, 1, 1);
	add_row("cancel_shl", odd_pipe_pkg::unit_perm, odd_pipe_pkg::op_shlqbyi, 15, 2, 0, 1, 0, 0);
	add_row("brz_nonzero", odd_pipe_pkg::unit_br, odd_pipe_pkg::op_brz, 0, 8, 50, 0, 1, 0);
	// Three units back to back, all in flight together
	add_row("mix_perm", odd_pipe_pkg::unit_perm, odd_pipe_pkg::op_rotqbyi, 16, 7, 0, 1, 0, 0);
	add_row("mix_ld", odd_pipe_pkg::unit_ls, odd_pipe_pkg::op_lqd, 21, 9, 0, 1, 0, 0);
	add_row("mix_brsl", odd_pipe_pkg::unit_br, odd_pipe_pkg::op_brsl, 30, 20, 100, 1, 0, 0);
	add_row("cancel_ld", odd_pipe_pkg::unit_ls, odd_pipe_pkg::op_lqd, 22, 4, 0, 1, 0, 0);
	add_row("br_far", odd_pipe_pkg::unit_br, odd_pipe_pkg::op_br, 0, 300, 200, 0, 1, 0);
	add_row("cancel_st", odd_pipe_pkg::unit_ls, odd_pipe_pkg::op_stqd, 0, 4, 0, 0, 0, 0);
	add_row("ld_after", odd_pipe_pkg::unit_ls, odd_pipe_pkg::op_lqd, 23, 4, 0, 1, 0, 0);
	add_row("brsl_wrap", odd_pipe_pkg::unit_br, odd_pipe_pkg::op_brsl, 31, 1, 255, 1, 1, 0);
	add_row("idle", odd_pipe_pkg::unit_none, odd_pipe_pkg::op_nop, 0, 0, 0, 0, 0, 0);
endtask

// ==== bench/odd_pipe_tb.sv ====
`include "odd_pipe_cfg.svh"

module odd_pipe_tb;

	localparam int MAX_ROWS = 32;
	localparam int QW = `ODD_QW_BITS;

	typedef struct packed {
		odd_pipe_pkg::unit_e       unit;
		odd_pipe_pkg::odd_op_e     op;
		logic [`ODD_ADDR_BITS-1:0] rt;
		logic [QW-1:0]             ra;
		logic [QW-1:0]             rb;
		logic [QW-1:0]             st;
		logic [`ODD_IMM_BITS-1:0]  imm;
		logic [`ODD_PC_BITS-1:0]   pc;
		logic                      rw;
		logic                      first;
		logic                      exp_wr;     // Writeback expected seven cycles on
		logic [QW-1:0]             exp_data;
		logic                      exp_taken;
		logic                      exp_kill;
		logic [`ODD_PC_BITS-1:0]   exp_pc;
	} row_t;

	logic                                         clk = 1'b0;
	logic                                         reset;
	logic                                         issue;
	odd_pipe_pkg::unit_e                          unit;
	odd_pipe_pkg::odd_op_e                        op;
	logic [`ODD_ADDR_BITS-1:0]                    rt_addr;
	logic [QW-1:0]                                ra, rb, rt_st;
	logic [`ODD_IMM_BITS-1:0]                     imm;
	logic                                         reg_write, first;
	logic [`ODD_PC_BITS-1:0]                      pc_in;
	logic [QW-1:0]                                rt_wb;
	logic [`ODD_ADDR_BITS-1:0]                    rt_addr_wb;
	logic                                         reg_write_wb, branch_taken, branch_kill;
	logic [`ODD_PC_BITS-1:0]                      pc_wb;
	logic [`ODD_FW_SLOTS-1:0][QW-1:0]             fw_data;
	logic [`ODD_FW_SLOTS-1:0][`ODD_ADDR_BITS-1:0] fw_addr;
	logic [`ODD_FW_SLOTS-1:0]                     fw_write;

	row_t          rows [0:MAX_ROWS-1];
	string         names [0:MAX_ROWS-1];
	int            n_rows = 0;
	logic [QW-1:0] ls_model [0:`ODD_LS_WORDS-1];  // Reference local store
	logic [QW-1:0] ls_base;                       // Common ra of all local store rows
	int            wb_queue [$];                  // Row index per cycle, -1 when idle
	int            errors = 0;
	int            checks = 0;
	int            cycles = 0;

	odd_pipe DUT (.*);

	always #20 clk = ~clk;

	function automatic logic [QW-1:0] random_qw();
		return {$urandom(), $urandom(), $urandom(), $urandom()};
	endfunction

	// Byte i of the result comes from byte i-n, counted from the low end
	function automatic logic [QW-1:0] permute_bytes(logic [QW-1:0] q, int n, bit rot);
		logic [QW-1:0] r;
		int src;
		r = '0;
		for (int i = 0; i < QW / 8; i++) begin
			src = i - n;
			if (src >= 0)
				r[i*8 +: 8] = q[src*8 +: 8];
			else if (rot)
				r[i*8 +: 8] = q[(src + QW / 8)*8 +: 8];  // Wrapped from the top
		end
		return r;
	endfunction

	// First chain slot that a unit's result enters
	function automatic int unit_latency(input odd_pipe_pkg::unit_e u);
		int lat;
		case (u)
			odd_pipe_pkg::unit_br: lat = `ODD_LAT_BR;
			odd_pipe_pkg::unit_ls: lat = `ODD_LAT_LS;
			default: lat = `ODD_LAT_PERM;              // unit_none runs on permute
		endcase
		return lat;
	endfunction

	task automatic add_row(input string name, input odd_pipe_pkg::unit_e u,
			input odd_pipe_pkg::odd_op_e o, input int rt, input int im, input int pc,
			input int rw, input int fst, input int rbz);
		row_t r;
		bit cancel;
		int la;
		cancel = (n_rows > 0) && rows[n_rows-1].exp_taken;  // Issued under a taken branch
		r = '0;
		r.unit = u;
		r.op = o;
		r.rt = 7'(rt);
		r.imm = 10'(im);
		r.pc = 8'(pc);
		r.rw = (rw != 0);
		r.first = (fst != 0);
		r.ra = (u == odd_pipe_pkg::unit_ls) ? ls_base : random_qw();
		r.rb = random_qw();
		r.rb[QW-1 -: 32] = (rbz != 0) ? 32'd0 : (r.rb[QW-1 -: 32] | 32'd1);
		r.st = random_qw();
		la = int'((r.ra[QW-1 -: 32] + 32'(im)) % `ODD_LS_WORDS);  // Word0 plus imm
		r.exp_taken = !cancel && (u == odd_pipe_pkg::unit_br) && ((o == odd_pipe_pkg::op_br)
			|| (o == odd_pipe_pkg::op_brsl) || ((o == odd_pipe_pkg::op_brz) && (rbz != 0)));
		r.exp_kill = r.exp_taken && r.first;
		r.exp_pc = 8'(pc + im);
		case (u)
			odd_pipe_pkg::unit_ls: begin
				r.exp_wr = !cancel && r.rw && (o == odd_pipe_pkg::op_lqd);
				r.exp_data = ls_model[la];
				if (!cancel && (o == odd_pipe_pkg::op_stqd))
					ls_model[la] = r.st;
			end
			odd_pipe_pkg::unit_br: begin
				r.exp_wr = !cancel && r.rw && (o == odd_pipe_pkg::op_brsl);
				r.exp_data = {{(QW - `ODD_PC_BITS){1'b0}}, 8'(pc + 1)};  // Link
			end
			default: begin                                     // Permute, also unit_none
				r.exp_wr = !cancel && r.rw;
				if (o == odd_pipe_pkg::op_shlqbyi)
					r.exp_data = permute_bytes(r.ra, im % 16, 1'b0);
				else if (o == odd_pipe_pkg::op_rotqbyi)
					r.exp_data = permute_bytes(r.ra, im % 16, 1'b1);
				else
					r.exp_data = r.ra;
			end
		endcase
		rows[n_rows] = r;
		names[n_rows] = name;
		n_rows++;
	endtask

	`include "odd_pipe_vectors.svh"

	task automatic drive_row(input int k);
		issue = 1'b1;
		unit = rows[k].unit;
		op = rows[k].op;
		rt_addr = rows[k].rt;
		ra = rows[k].ra;
		rb = rows[k].rb;
		rt_st = rows[k].st;
		imm = rows[k].imm;
		reg_write = rows[k].rw;
		pc_in = rows[k].pc;
		first = rows[k].first;
	endtask

	task automatic drive_idle();
		issue = 1'b0;
		unit = odd_pipe_pkg::unit_none;
		op = odd_pipe_pkg::op_nop;
		rt_addr = '0;
		ra = '0;
		rb = '0;
		rt_st = '0;
		imm = '0;
		reg_write = 1'b0;
		pc_in = '0;
		first = 1'b0;
	endtask

	function automatic string row_name(input int j);
		return (j >= 0) ? names[j] : "drain";
	endfunction

	task automatic report_mismatch(input string name, input string field,
			input logic [QW-1:0] exp, input logic [QW-1:0] act);
		errors++;
		$display("mismatch %s %s: expected %h actual %h", name, field, exp, act);
	endtask

	// Branch outputs belong to the row sampled on the last rising edge
	task automatic check_branch(input int j);
		checks++;
		if (branch_taken !== rows[j].exp_taken)
			report_mismatch(names[j], "branch_taken", QW'(rows[j].exp_taken), QW'(branch_taken));
		if (branch_kill !== rows[j].exp_kill)
			report_mismatch(names[j], "branch_kill", QW'(rows[j].exp_kill), QW'(branch_kill));
		if (rows[j].exp_taken && (pc_wb !== rows[j].exp_pc))
			report_mismatch(names[j], "pc_wb", QW'(rows[j].exp_pc), QW'(pc_wb));
	endtask

	// Slot n holds the row issued n edges ago, once its unit has reached slot n
	task automatic check_chain();
		int j;
		logic ew;
		for (int n = 1; n < `ODD_FW_SLOTS; n++) begin
			j = wb_queue[`ODD_WB_LAT - n];
			ew = (j >= 0) && rows[j].exp_wr && (unit_latency(rows[j].unit) <= n);
			checks++;
			if (fw_write[n] !== ew)
				report_mismatch(row_name(j), $sformatf("fw_write[%0d]", n), QW'(ew),
					QW'(fw_write[n]));
			if (ew && (fw_addr[n] !== rows[j].rt))
				report_mismatch(names[j], $sformatf("fw_addr[%0d]", n), QW'(rows[j].rt),
					QW'(fw_addr[n]));
			if (ew && (fw_data[n] !== rows[j].exp_data))
				report_mismatch(names[j], $sformatf("fw_data[%0d]", n), rows[j].exp_data,
					fw_data[n]);
		end
	endtask

	task automatic check_writeback(input int j);
		logic ew;
		ew = (j >= 0) && rows[j].exp_wr;
		checks++;
		if (reg_write_wb !== ew)
			report_mismatch(row_name(j), "reg_write_wb", QW'(ew), QW'(reg_write_wb));
		if (ew && (rt_addr_wb !== rows[j].rt))
			report_mismatch(names[j], "rt_addr_wb", QW'(rows[j].rt), QW'(rt_addr_wb));
		if (ew && (rt_wb !== rows[j].exp_data))
			report_mismatch(names[j], "rt_wb", rows[j].exp_data, rt_wb);
	endtask

	initial begin
		reset = 1'b1;
		drive_idle();
		void'($urandom(16));
		ls_base = random_qw();
		load_table();
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		checks++;
		if ((reg_write_wb !== 1'b0) || (fw_write !== '0)) begin
			errors++;
			$display("reset left reg_write_wb or fw_write set");
		end
		for (int k = 0; k < n_rows + `ODD_WB_LAT + 1; k++) begin
			if ((k > 0) && (k <= n_rows))
				check_branch(k - 1);
			if (wb_queue.size() == `ODD_WB_LAT + 1) begin  // Oldest row reached writeback
				check_chain();
				check_writeback(wb_queue.pop_front());
			end
			if (k < n_rows) begin
				drive_row(k);
				wb_queue.push_back(k);
			end else begin
				drive_idle();                              // Drain the pipe
				wb_queue.push_back(-1);
			end
			@(negedge clk);
		end
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) begin
			$display("SIMULATION PASSED");
		end else begin
			$display("SIMULATION FAILED");
		end
		$finish;
	end

	// Table, drain and reset fit well inside this limit
	always @(posedge clk) begin
		cycles++;
		if (cycles > n_rows + 20) begin
			$display("timeout after %0d cycles, table loop did not finish", cycles);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

endmodule

// ==== odd_pipe.f ====
+incdir+rtl
+incdir+bench
rtl/odd_pipe_pkg.sv
rtl/odd_issue_if.sv
rtl/permute_unit.sv
rtl/local_store_unit.sv
rtl/branch_unit.sv
rtl/odd_pipe.sv
bench/odd_pipe_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build with Verilator, run the testbench, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f odd_pipe.f --top-module odd_pipe_tb -o odd_pipe_sim \
	> build.log 2>&1 &&
	./obj_dir/odd_pipe_sim > sim.log 2>&1 ||
	{ cat build.log; echo "build or run failed"; exit 1; }
grep -q "^SIMULATION PASSED$" sim.log && echo "PASS" ||
	{ cat sim.log; echo "FAIL"; exit 1; }
